//--- run_sim.sh
#!/bin/sh
# build and run the pod row sdr testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module pod_row_sdr_tb \
  -o sim_pod_row > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_pod_row > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- verif/pod_row_sdr_asserts.sv
// north sdr block assertions
// credit use on the forward link, token pulse width and fifo
// overflow and underflow, bound into every north block

`timescale 1ns/10ps

module pod_row_sdr_asserts
  import sdr_link_pkg::*;
  (input  logic    core_clk_i
  , input  logic    rst_n_i
  , input  logic    core_v_in_i
  , input  logic    core_ready_out_i
  , input  sdr_io_s fwd_out_i
  , input  logic    token_in_i
  , input  logic    token_out_i
  , input  logic    send_i
  , input  sdr_io_s fwd_in_i
  , input  logic    rx_full_i
  , input  logic    rx_yumi_i
  );

  localparam int CNT_W = LG_FIFO_DEPTH + 2;

  // credit and fifo occupancy counts rebuilt from traffic
  logic [CNT_W-1:0] credit_cnt;
  logic [CNT_W-1:0] tx_cnt;
  logic [CNT_W-1:0] rx_cnt;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt <= CNT_W'(FIFO_DEPTH);
      tx_cnt     <= '0;
      rx_cnt     <= '0;
    end else begin
      credit_cnt <= credit_cnt - CNT_W'(fwd_out_i.v)
                  + (token_in_i ? CNT_W'(CREDITS_PER_TOKEN) : '0);
      tx_cnt     <= tx_cnt + CNT_W'(core_v_in_i & core_ready_out_i) - CNT_W'(send_i);
      rx_cnt     <= rx_cnt + CNT_W'(fwd_in_i.v) - CNT_W'(rx_yumi_i);
    end
  end

  // count still holds the credit this packet was sent on
  fwd_needs_credit: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    fwd_out_i.v |-> (credit_cnt != '0))
    else $error("forward packet sent without credit");

  // one cycle per token
  token_single_cycle: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    token_out_i |=> !token_out_i)
    else $error("token held high two cycles");

  tx_push_not_full: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (core_v_in_i & core_ready_out_i) |-> (tx_cnt != CNT_W'(FIFO_DEPTH)))
    else $error("transmit fifo written while full");

  tx_pop_not_empty: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    send_i |-> (tx_cnt != '0))
    else $error("transmit fifo popped while empty");

  rx_push_not_full: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    fwd_in_i.v |-> !rx_full_i)
    else $error("receive fifo written while full");

  rx_pop_not_empty: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    rx_yumi_i |-> (rx_cnt != '0))
    else $error("receive fifo popped while empty");

endmodule

bind sdr_link_north pod_row_sdr_asserts link_asserts (
  .core_clk_i       (core_clk_i)
  ,.rst_n_i         (rst_n_i)
  ,.core_v_in_i     (core_v_i)
  ,.core_ready_out_i(core_ready_o)
  ,.fwd_out_i       (io_fwd_o)
  ,.token_in_i      (io_token_i)
  ,.token_out_i     (io_token_o)
  ,.send_i          (send)
  ,.fwd_in_i        (io_fwd_i)
  ,.rx_full_i       (rx_full)
  ,.rx_yumi_i       (rx_yumi)
);

//--- verif/pod_row_sdr_tb.sv
// pod row sdr testbench
// drives a table of tag frames, coordinates and packets into the row,
// loops each tile's forward link and tokens back onto itself and
// drains the receive side under pseudo-random back-pressure

`timescale 1ns/10ps

module pod_row_sdr_tb
  import pod_cfg_pkg::*;
  import sdr_link_pkg::*;
  ();

  localparam int NUM_ENTRIES = 16;
  localparam int MAX_CYCLES  = 40 * NUM_ENTRIES + 200;
  localparam int NUM_TESTS   = 6;
  localparam int TILE_W      = $clog2(TOTAL_TILES_X);

  typedef enum logic [1:0] {ENT_TAG, ENT_CORD, ENT_PKT} ent_kind_e;

  // tile holds the pod number for tag entries
  typedef struct packed {
    ent_kind_e         kind;
    logic [TILE_W-1:0] tile;
    logic              payload;
    tile_cord_s        cord;
    sdr_pkt_s          pkt;
  } entry_s;

  logic core_clk;
  logic rst_n;
  logic tag_bit;
  tile_cord_s [TOTAL_TILES_X-1:0] global_cord;
  tile_cord_s [TOTAL_TILES_X-1:0] pod_cord;
  logic [TOTAL_TILES_X-1:0] pod_reset;
  logic [TOTAL_TILES_X-1:0] core_v_tx;
  sdr_pkt_s [TOTAL_TILES_X-1:0] core_pkt_tx;
  logic [TOTAL_TILES_X-1:0] core_ready_tx;
  logic [TOTAL_TILES_X-1:0] core_v_rx;
  sdr_pkt_s [TOTAL_TILES_X-1:0] core_pkt_rx;
  logic [TOTAL_TILES_X-1:0] core_ready_rx = '0;
  sdr_io_s [TOTAL_TILES_X-1:0] io_fwd_out;
  sdr_io_s [TOTAL_TILES_X-1:0] io_fwd_in;
  logic [TOTAL_TILES_X-1:0] io_token_out;
  logic [TOTAL_TILES_X-1:0] io_token_in;
  logic [TOTAL_TILES_X-1:0] token_en;

  entry_s stim [NUM_ENTRIES];
  sdr_pkt_s exp_q [TOTAL_TILES_X][$];
  int drain_left [TOTAL_TILES_X];
  int drain_test;
  int sent_cnt [TOTAL_TILES_X];
  int token_cnt [TOTAL_TILES_X];
  int errors [1:NUM_TESTS];
  int tests_failed;
  int cycle_cnt;
  logic exp_rst [NUM_PODS_X];
  logic [15:0] lfsr = 16'd20997;

  pod_row_sdr dut (
    .core_clk_i    (core_clk)
    ,.rst_n_i      (rst_n)
    ,.tag_bit_i    (tag_bit)
    ,.global_cord_i(global_cord)
    ,.pod_reset_o  (pod_reset)
    ,.pod_cord_o   (pod_cord)
    ,.core_v_i     (core_v_tx)
    ,.core_pkt_i   (core_pkt_tx)
    ,.core_ready_o (core_ready_tx)
    ,.core_v_o     (core_v_rx)
    ,.core_pkt_o   (core_pkt_rx)
    ,.core_ready_i (core_ready_rx)
    ,.io_fwd_o     (io_fwd_out)
    ,.io_token_i   (io_token_in)
    ,.io_fwd_i     (io_fwd_in)
    ,.io_token_o   (io_token_out)
  );

  // each tile talks to itself, token return can be cut per tile
  assign io_fwd_in   = io_fwd_out;
  assign io_token_in = io_token_out & token_en;

  initial core_clk = 1'b0;
  always #50 core_clk = ~core_clk;

  always @(posedge core_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  // pulse counters, sampled mid-cycle
  always @(negedge core_clk) begin
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      if (io_fwd_out[t].v) sent_cnt[t]++;
      if (io_token_out[t]) token_cnt[t]++;
    end
  end

  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    return b;
  endfunction

  task automatic check_pkt(input int test, input string name, input sdr_pkt_s exp,
                           input sdr_pkt_s act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      errors[test]++;
    end
  endtask

  task automatic check_cord(input int test, input string name, input tile_cord_s exp,
                            input tile_cord_s act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      errors[test]++;
    end
  endtask

  task automatic check_bit(input int test, input string name, input logic exp,
                           input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
      errors[test]++;
    end
  endtask

  task automatic check_count(input int test, input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
      errors[test]++;
    end
  endtask

  // receive side drain with random ready, checks order per tile
  always @(posedge core_clk) begin
    logic rdy;
    #10;
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      rdy = 1'b0;
      if (drain_left[t] > 0) begin
        rdy = rand_bit();
        if (rdy && core_v_rx[t]) begin
          if (exp_q[t].size() == 0) begin
            $display("tile %0d delivered a packet that was never sent", t);
            errors[drain_test]++;
          end else begin
            check_pkt(drain_test, $sformatf("core_pkt_o[%0d]", t), exp_q[t].pop_front(),
                      core_pkt_rx[t]);
          end
          drain_left[t]--;
        end
      end
      core_ready_rx[t] = rdy;
    end
  end

  task automatic tick();
    @(posedge core_clk);
    #10;
  endtask

  function automatic entry_s tag_ent(input int pod, input logic payload);
    entry_s e;
    e = '0;
    e.kind = ENT_TAG;
    e.tile = TILE_W'(pod);
    e.payload = payload;
    return e;
  endfunction

  function automatic entry_s cord_ent(input int t, input int x, input int y);
    entry_s e;
    e = '0;
    e.kind = ENT_CORD;
    e.tile = TILE_W'(t);
    e.cord.x = X_CORD_WIDTH'(x);
    e.cord.y = Y_CORD_WIDTH'(y);
    return e;
  endfunction

  function automatic entry_s pkt_ent(input int t, input sdr_op_e op, input int addr,
                                     input int data);
    entry_s e;
    e = '0;
    e.kind = ENT_PKT;
    e.tile = TILE_W'(t);
    e.pkt.op = op;
    e.pkt.addr = ADDR_WIDTH'(addr);
    e.pkt.data = DATA_WIDTH'(data);
    return e;
  endfunction

  // frame is start, node id, payload on consecutive cycles
  task automatic send_tag(input int pod, input logic payload);
    tag_bit = 1'b1;
    tick();
    tag_bit = pod[0];
    tick();
    tag_bit = payload;
    tick();
    tag_bit = 1'b0;
    repeat (2) tick();
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      check_bit(2, $sformatf("pod_reset_o[%0d]", t), exp_rst[t / NUM_TILES_X], pod_reset[t]);
    end
    exp_rst[pod] = payload;
    tick();
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      check_bit(2, $sformatf("pod_reset_o[%0d]", t), exp_rst[t / NUM_TILES_X], pod_reset[t]);
    end
  endtask

  // pod side keeps the old value until the next edge
  task automatic apply_cord(input int t, input tile_cord_s cord);
    tile_cord_s prev;
    prev = global_cord[t];
    global_cord[t] = cord;
    #1;
    check_cord(3, $sformatf("pod_cord_o[%0d]", t), prev, pod_cord[t]);
    tick();
    check_cord(3, $sformatf("pod_cord_o[%0d]", t), cord, pod_cord[t]);
  endtask

  // hold the packet until the tile takes it
  task automatic push_pkt(input int t, input sdr_pkt_s pkt);
    logic ok;
    core_v_tx[t] = 1'b1;
    core_pkt_tx[t] = pkt;
    exp_q[t].push_back(pkt);
    do begin
      ok = core_ready_tx[t];
      tick();
    end while (!ok);
    core_v_tx[t] = 1'b0;
  endtask

  function automatic bit any_pending();
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      if (exp_q[t].size() != 0) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic report_test(input int test, input string name);
    if (errors[test] == 0) begin
      $display("test %0d %s: ok", test, name);
    end else begin
      $display("test %0d %s: %0d errors", test, name, errors[test]);
      tests_failed++;
    end
  endtask

  initial begin
    int base_sent;
    int base_tok;
    sdr_pkt_s p;
    rst_n = 1'b0;
    tag_bit = 1'b0;
    global_cord = '0;
    core_v_tx = '0;
    core_pkt_tx = '0;
    token_en = '1;
    drain_test = 4;
    foreach (exp_rst[i]) exp_rst[i] = 1'b0;
    stim[0]  = cord_ent(0, 1, 8);
    stim[1]  = cord_ent(1, 2, 8);
    stim[2]  = cord_ent(2, 3, 8);
    stim[3]  = cord_ent(3, 4, 8);
    stim[4]  = pkt_ent(0, OP_LOAD, 'h10, 'h1234);
    stim[5]  = pkt_ent(1, OP_STORE, 'h21, 'hbeef);
    stim[6]  = tag_ent(0, 1'b1);
    stim[7]  = pkt_ent(2, OP_AMO, 'h32, 'h0f0f);
    stim[8]  = pkt_ent(3, OP_STORE, 'h43, 'ha5a5);
    stim[9]  = tag_ent(1, 1'b1);
    stim[10] = pkt_ent(0, OP_STORE, 'h14, 'h5678);
    stim[11] = pkt_ent(1, OP_AMO, 'h25, 'hffff);
    stim[12] = tag_ent(0, 1'b0);
    stim[13] = pkt_ent(2, OP_LOAD, 'h36, 'h0000);
    stim[14] = pkt_ent(3, OP_LOAD, 'h47, 'h8001);
    stim[15] = tag_ent(1, 1'b0);

    repeat (5) @(posedge core_clk);
    #10 rst_n = 1'b1;
    tick();
    for (int t = 0; t < TOTAL_TILES_X; t++) begin
      check_bit(1, $sformatf("io_fwd_o[%0d].v", t), 1'b0, io_fwd_out[t].v);
      check_bit(1, $sformatf("io_token_o[%0d]", t), 1'b0, io_token_out[t]);
      check_bit(1, $sformatf("core_v_o[%0d]", t), 1'b0, core_v_rx[t]);
      check_bit(1, $sformatf("pod_reset_o[%0d]", t), 1'b0, pod_reset[t]);
      check_bit(1, $sformatf("core_ready_o[%0d]", t), 1'b1, core_ready_tx[t]);
    end
    report_test(1, "reset state");

    foreach (drain_left[t]) drain_left[t] = 1000;
    foreach (stim[i]) begin
      case (stim[i].kind)
        ENT_TAG:  send_tag(int'(stim[i].tile), stim[i].payload);
        ENT_CORD: apply_cord(int'(stim[i].tile), stim[i].cord);
        default:  push_pkt(int'(stim[i].tile), stim[i].pkt);
      endcase
    end
    while (any_pending()) tick();
    foreach (drain_left[t]) drain_left[t] = 0;
    // let the last tokens refill the credits
    repeat (3) tick();
    report_test(2, "tag driven reset");
    report_test(3, "coordinate forwarding");
    report_test(4, "ordered loopback");

    token_en[0] = 1'b0;
    base_sent = sent_cnt[0];
    for (int i = 0; i < 2 * FIFO_DEPTH; i++) begin
      p.op = OP_STORE;
      p.addr = ADDR_WIDTH'(128 + i);
      p.data = DATA_WIDTH'(i * 257);
      push_pkt(0, p);
    end
    check_bit(5, "core_ready_o[0]", 1'b0, core_ready_tx[0]);
    repeat (4) tick();
    check_count(5, "io_fwd_o[0].v pulses", FIFO_DEPTH, sent_cnt[0] - base_sent);
    check_bit(5, "core_ready_o[0]", 1'b0, core_ready_tx[0]);
    report_test(5, "credit limit");

    drain_test = 6;
    token_en[0] = 1'b1;
    base_tok = token_cnt[0];
    drain_left[0] = FIFO_DEPTH;
    while (drain_left[0] != 0) tick();
    repeat (3) tick();
    check_count(6, "io_token_o[0] pulses", FIFO_DEPTH / CREDITS_PER_TOKEN,
                token_cnt[0] - base_tok);
    drain_left[0] = 1000;
    while (exp_q[0].size() != 0) tick();
    repeat (3) tick();
    check_count(6, "io_fwd_o[0].v pulses", 2 * FIFO_DEPTH, sent_cnt[0] - base_sent);
    check_count(6, "io_token_o[0] pulses", 2 * FIFO_DEPTH / CREDITS_PER_TOKEN,
                token_cnt[0] - base_tok);
    check_bit(6, "core_ready_o[0]", 1'b1, core_ready_tx[0]);
    check_bit(6, "core_v_o[0]", 1'b0, core_v_rx[0]);
    report_test(6, "token decimation");

    $display("%0d tests run, %0d failed", NUM_TESTS, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verilog/pod_cfg_pkg.sv
// pod configuration package
// geometry of the pod row, tile coordinate format and the framing
// of the serial tag line that carries each pod's reset level

package pod_cfg_pkg;

  // row geometry
  localparam int NUM_PODS_X    = 2;
  localparam int NUM_TILES_X   = 2;
  localparam int TOTAL_TILES_X = NUM_PODS_X * NUM_TILES_X;

  // global coordinate widths
  localparam int X_CORD_WIDTH = 7;
  localparam int Y_CORD_WIDTH = 7;

  // tag frame is start bit, node id, payload
  localparam int TAG_NODE_WIDTH = 1;

  // registers between the tag payload and the pod
  localparam int RESET_CHAIN_STAGES = 2;

  typedef struct packed {
    logic [X_CORD_WIDTH-1:0] x;
    logic [Y_CORD_WIDTH-1:0] y;
  } tile_cord_s;

  // tag receiver position within a frame
  typedef enum logic [1:0] {
    TAG_IDLE = 2'd0,
    TAG_NODE = 2'd1,
    TAG_DATA = 2'd2
  } tag_state_e;

endpackage

//--- verilog/pod_row_sdr.sv
// pod row sdr edge
// one row of pods with its north sdr blocks. a tag client per pod
// recovers the pod reset level from the serial tag line and each
// tile's north block forwards reset, coordinates and packets between
// the core ports and the i/o links.

`timescale 1ns/10ps

module pod_row_sdr
  import pod_cfg_pkg::*;
  import sdr_link_pkg::*;
  (input  logic                           core_clk_i
  , input  logic                           rst_n_i
  , input  logic                           tag_bit_i
  , input  tile_cord_s [TOTAL_TILES_X-1:0] global_cord_i
  , output logic       [TOTAL_TILES_X-1:0] pod_reset_o
  , output tile_cord_s [TOTAL_TILES_X-1:0] pod_cord_o
  , input  logic       [TOTAL_TILES_X-1:0] core_v_i
  , input  sdr_pkt_s   [TOTAL_TILES_X-1:0] core_pkt_i
  , output logic       [TOTAL_TILES_X-1:0] core_ready_o
  , output logic       [TOTAL_TILES_X-1:0] core_v_o
  , output sdr_pkt_s   [TOTAL_TILES_X-1:0] core_pkt_o
  , input  logic       [TOTAL_TILES_X-1:0] core_ready_i
  , output sdr_io_s    [TOTAL_TILES_X-1:0] io_fwd_o
  , input  logic       [TOTAL_TILES_X-1:0] io_token_i
  , input  sdr_io_s    [TOTAL_TILES_X-1:0] io_fwd_i
  , output logic       [TOTAL_TILES_X-1:0] io_token_o
  );

  logic [NUM_PODS_X-1:0] pod_reset_lo;

  for (genvar p = 0; p < NUM_PODS_X; p++) begin : pod
    tag_client #(
      .node_id_p(TAG_NODE_WIDTH'(p))
    ) tc (
      .core_clk_i  (core_clk_i)
      ,.rst_n_i    (rst_n_i)
      ,.tag_bit_i  (tag_bit_i)
      ,.pod_reset_o(pod_reset_lo[p])
    );
  end

  // tiles of a pod share that pod's reset level
  for (genvar t = 0; t < TOTAL_TILES_X; t++) begin : tile
    sdr_link_north sdr_n (
      .core_clk_i    (core_clk_i)
      ,.rst_n_i      (rst_n_i)
      ,.core_reset_i (pod_reset_lo[t / NUM_TILES_X])
      ,.global_cord_i(global_cord_i[t])
      ,.pod_reset_o  (pod_reset_o[t])
      ,.pod_cord_o   (pod_cord_o[t])
      ,.core_v_i     (core_v_i[t])
      ,.core_pkt_i   (core_pkt_i[t])
      ,.core_ready_o (core_ready_o[t])
      ,.core_v_o     (core_v_o[t])
      ,.core_pkt_o   (core_pkt_o[t])
      ,.core_ready_i (core_ready_i[t])
      ,.io_fwd_o     (io_fwd_o[t])
      ,.io_token_i   (io_token_i[t])
      ,.io_fwd_i     (io_fwd_i[t])
      ,.io_token_o   (io_token_o[t])
    );
  end

endmodule

//--- verilog/sdr_credit_counter.sv
// sdr credit counter
// tracks free slots in the remote receive fifo. starts full, spends
// one credit per packet sent and gets a decimated batch back on each
// returning token.

`timescale 1ns/10ps

module sdr_credit_counter
  import sdr_link_pkg::*;
  (input  logic core_clk_i
  , input  logic rst_n_i
  , input  logic send_i
  , input  logic token_i
  , output logic credit_avail_o
  );

  logic [LG_FIFO_DEPTH:0] count_r;
  logic [LG_FIFO_DEPTH:0] count_n;

  // send and token may land in the same cycle
  always_comb begin
    count_n = count_r;
    if (send_i) begin
      count_n = count_n - 1'b1;
    end
    if (token_i) begin
      count_n = count_n + (LG_FIFO_DEPTH+1)'(CREDITS_PER_TOKEN);
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_r <= (LG_FIFO_DEPTH+1)'(FIFO_DEPTH);
    end else begin
      count_r <= count_n;
    end
  end

  assign credit_avail_o = (count_r != '0);

endmodule

//--- verilog/sdr_fifo.sv
// sdr fifo
// circular buffer of sdr packets with a wrap bit on each pointer to
// tell full from empty. head is presented combinationally, popped
// with yumi_i.

`timescale 1ns/10ps

module sdr_fifo
  import sdr_link_pkg::*;
  (input  logic     core_clk_i
  , input  logic     rst_n_i
  , input  logic     v_i
  , input  sdr_pkt_s pkt_i
  , output logic     full_o
  , output logic     v_o
  , output sdr_pkt_s pkt_o
  , input  logic     yumi_i
  );

  sdr_pkt_s mem_r [FIFO_DEPTH];
  logic [LG_FIFO_DEPTH:0] wr_ptr_r;
  logic [LG_FIFO_DEPTH:0] rd_ptr_r;

  // same slot, different lap means full
  assign full_o = (wr_ptr_r[LG_FIFO_DEPTH] != rd_ptr_r[LG_FIFO_DEPTH])
               && (wr_ptr_r[LG_FIFO_DEPTH-1:0] == rd_ptr_r[LG_FIFO_DEPTH-1:0]);
  assign v_o    = (wr_ptr_r != rd_ptr_r);
  assign pkt_o  = mem_r[rd_ptr_r[LG_FIFO_DEPTH-1:0]];

  always_ff @(posedge core_clk_i) begin
    if (v_i) begin
      mem_r[wr_ptr_r[LG_FIFO_DEPTH-1:0]] <= pkt_i;
    end
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (v_i) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

endmodule

//--- verilog/sdr_link_north.sv
// north sdr block
// one per tile on the north edge. registers the pod reset level and
// the tile coordinates on their way into the pod, sends core packets
// out over a credit-controlled forward link, and buffers packets from
// the link for the core, returning one token per decimated batch of
// dequeues.

`timescale 1ns/10ps

module sdr_link_north
  import pod_cfg_pkg::*;
  import sdr_link_pkg::*;
  (input  logic       core_clk_i
  , input  logic       rst_n_i
  , input  logic       core_reset_i
  , input  tile_cord_s global_cord_i
  , output logic       pod_reset_o
  , output tile_cord_s pod_cord_o
  , input  logic       core_v_i
  , input  sdr_pkt_s   core_pkt_i
  , output logic       core_ready_o
  , output logic       core_v_o
  , output sdr_pkt_s   core_pkt_o
  , input  logic       core_ready_i
  , output sdr_io_s    io_fwd_o
  , input  logic       io_token_i
  , input  sdr_io_s    io_fwd_i
  , output logic       io_token_o
  );

  logic tx_full;
  logic tx_v;
  sdr_pkt_s tx_pkt;
  logic credit_avail;
  logic send;
  logic io_v_r;
  sdr_pkt_s io_pkt_r;

  logic rx_full;
  logic rx_yumi;
  logic [LG_CREDIT_TO_TOKEN_DECIMATION-1:0] deq_cnt_r;
  logic io_token_r;

  // reset level and coordinates toward the pod
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pod_reset_o <= 1'b0;
    end else begin
      pod_reset_o <= core_reset_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    pod_cord_o <= global_cord_i;
  end

  // transmit path
  assign core_ready_o = ~tx_full;

  sdr_fifo tx_fifo (
    .core_clk_i (core_clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.v_i       (core_v_i & ~tx_full)
    ,.pkt_i     (core_pkt_i)
    ,.full_o    (tx_full)
    ,.v_o       (tx_v)
    ,.pkt_o     (tx_pkt)
    ,.yumi_i    (send)
  );

  sdr_credit_counter credits (
    .core_clk_i     (core_clk_i)
    ,.rst_n_i       (rst_n_i)
    ,.send_i        (send)
    ,.token_i       (io_token_i)
    ,.credit_avail_o(credit_avail)
  );

  assign send = tx_v & credit_avail;

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      io_v_r <= 1'b0;
    end else begin
      io_v_r <= send;
    end
  end

  always_ff @(posedge core_clk_i) begin
    io_pkt_r <= tx_pkt;
  end

  assign io_fwd_o = '{v: io_v_r, pkt: io_pkt_r};

  // receive path, remote never overruns thanks to credits
  sdr_fifo rx_fifo (
    .core_clk_i (core_clk_i)
    ,.rst_n_i   (rst_n_i)
    ,.v_i       (io_fwd_i.v)
    ,.pkt_i     (io_fwd_i.pkt)
    ,.full_o    (rx_full)
    ,.v_o       (core_v_o)
    ,.pkt_o     (core_pkt_o)
    ,.yumi_i    (rx_yumi)
  );

  assign rx_yumi = core_v_o & core_ready_i;

  // token on every wrap of the dequeue count
  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      deq_cnt_r  <= '0;
      io_token_r <= 1'b0;
    end else begin
      io_token_r <= rx_yumi & (&deq_cnt_r);
      if (rx_yumi) begin
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
    end
  end

  assign io_token_o = io_token_r;

endmodule

//--- verilog/sdr_link_pkg.sv
// sdr link package
// packet format, i/o channel format and buffering constants shared by
// the north sdr blocks, their fifos and their credit counters

package sdr_link_pkg;

  // packet fields
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 16;

  // buffering on both ends of the link
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;

  // one token returns this many credits
  localparam int LG_CREDIT_TO_TOKEN_DECIMATION = 1;
  localparam int CREDITS_PER_TOKEN             = 1 << LG_CREDIT_TO_TOKEN_DECIMATION;

  // carried through the link, not decoded here
  typedef enum logic [1:0] {
    OP_LOAD  = 2'd0,
    OP_STORE = 2'd1,
    OP_AMO   = 2'd2
  } sdr_op_e;

  typedef struct packed {
    sdr_op_e               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } sdr_pkt_s;

  // i/o side channel, v high for one cycle per packet
  typedef struct packed {
    logic     v;
    sdr_pkt_s pkt;
  } sdr_io_s;

endpackage

//--- verilog/tag_client.sv
// tag client
// receives frames on the shared serial tag line. a frame is a start
// bit, the node id and one payload bit. frames addressed to node_id_p
// update the held reset level, which then passes through a short
// register chain toward the pod.

`timescale 1ns/10ps

module tag_client
  import pod_cfg_pkg::*;
  #(parameter logic [TAG_NODE_WIDTH-1:0] node_id_p = '0
  )
  (input  logic core_clk_i
  , input  logic rst_n_i
  , input  logic tag_bit_i
  , output logic pod_reset_o
  );

  tag_state_e state_r;
  tag_state_e state_n;
  logic node_hit_r;
  logic payload_r;
  logic [RESET_CHAIN_STAGES-1:0] chain_r;

  // one bit per state, line idles low
  always_comb begin
    state_n = state_r;
    case (state_r)
      TAG_IDLE: begin
        if (tag_bit_i) begin
          state_n = TAG_NODE;
        end
      end
      TAG_NODE: begin
        state_n = TAG_DATA;
      end
      TAG_DATA: begin
        state_n = TAG_IDLE;
      end
      default: begin
        state_n = TAG_IDLE;
      end
    endcase
  end

  always_ff @(posedge core_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r    <= TAG_IDLE;
      node_hit_r <= 1'b0;
      payload_r  <= 1'b0;
      chain_r    <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == TAG_NODE) begin
        node_hit_r <= (TAG_NODE_WIDTH'(tag_bit_i) == node_id_p);
      end
      // other nodes' frames leave the level alone
      if ((state_r == TAG_DATA) && node_hit_r) begin
        payload_r <= tag_bit_i;
      end
      chain_r <= {chain_r[RESET_CHAIN_STAGES-2:0], payload_r};
    end
  end

  assign pod_reset_o = chain_r[RESET_CHAIN_STAGES-1];

endmodule

//--- vlog.f
verilog/pod_cfg_pkg.sv
verilog/sdr_link_pkg.sv
verilog/tag_client.sv
verilog/sdr_fifo.sv
verilog/sdr_credit_counter.sv
verilog/sdr_link_north.sv
verilog/pod_row_sdr.sv
verif/pod_row_sdr_asserts.sv
verif/pod_row_sdr_tb.sv
